// ==== rtl/gat_dims_pkg.sv ====
`default_nettype none

package gat_dims_pkg;

  // ========================================
  // Layer dimensions
  // ========================================
  localparam int DATA_WIDTH      = 8;
  localparam int TOTAL_NODES     = 16;
  localparam int NUM_FEATURE_IN  = 8;
  localparam int NUM_FEATURE_OUT = 4;
  localparam int MAX_NODES       = 8;

  // Memory depths
  localparam int H_DATA_DEPTH    = 64;
  localparam int WEIGHT_DEPTH    = NUM_FEATURE_IN * NUM_FEATURE_OUT + 2 * NUM_FEATURE_OUT;
  // a_src then a_dst follow the W matrix
  localparam int A_BASE          = NUM_FEATURE_IN * NUM_FEATURE_OUT;

  // Field and address widths
  localparam int COL_IDX_WIDTH   = $clog2(NUM_FEATURE_IN);
  localparam int ROW_LEN_WIDTH   = $clog2(NUM_FEATURE_IN + 1);
  localparam int NUM_NODE_WIDTH  = $clog2(MAX_NODES + 1);
  localparam int WGT_COL_WIDTH   = $clog2(NUM_FEATURE_OUT);
  localparam int H_DATA_ADDR_W   = $clog2(H_DATA_DEPTH);
  localparam int NODE_ADDR_W     = $clog2(TOTAL_NODES);
  localparam int WEIGHT_ADDR_W   = $clog2(WEIGHT_DEPTH);

  // Engine counters
  localparam int COEF_CNT_W      = $clog2(2 * NUM_FEATURE_OUT + 1);
  localparam int MAC_CNT_W       = $clog2(NUM_FEATURE_OUT + 1);

  // ========================================
  // Arithmetic
  // ========================================
  localparam int WH_DATA_WIDTH   = 20;
  localparam int SCORE_WIDTH     = 32;
  localparam int LEAKY_SHIFT     = 3;

endpackage

`default_nettype wire

// ==== rtl/gat_types_pkg.sv ====
`default_nettype none

package gat_types_pkg;

  import gat_dims_pkg::*;

  // ========================================
  // Memory entries
  // ========================================
  typedef logic signed [DATA_WIDTH-1:0] weight_t;

  typedef struct packed {
    logic signed [DATA_WIDTH-1:0] value;
    logic [COL_IDX_WIDTH-1:0]     col;
  } h_entry_t;

  // first is set on the subgraph's first node
  typedef struct packed {
    logic [ROW_LEN_WIDTH-1:0]  row_len;
    logic [NUM_NODE_WIDTH-1:0] num_nodes;
    logic                      first;
  } node_info_t;

  // Host write ports
  typedef struct packed {
    logic                     ena;
    logic                     wea;
    logic [H_DATA_ADDR_W-1:0] addr;
    h_entry_t                 din;
  } h_wr_t;

  typedef struct packed {
    logic                   ena;
    logic                   wea;
    logic [NODE_ADDR_W-1:0] addr;
    node_info_t             din;
  } node_info_wr_t;

  typedef struct packed {
    logic                     ena;
    logic                     wea;
    logic [WEIGHT_ADDR_W-1:0] addr;
    weight_t                  din;
  } wgt_wr_t;

  // ========================================
  // Engine to attention
  // ========================================
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_elem_t;
  typedef wh_elem_t [NUM_FEATURE_OUT-1:0] wh_vec_t;

  typedef struct packed {
    wh_vec_t                wh;
    logic [NODE_ADDR_W-1:0] node;
    logic                   first;
  } wh_item_t;

  typedef struct packed {
    weight_t [NUM_FEATURE_OUT-1:0] src;
    weight_t [NUM_FEATURE_OUT-1:0] dst;
  } attn_vec_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_COEF,
    FETCH_INFO,
    FETCH_ENTRY,
    MAC,
    EMIT,
    DONE
  } engine_state_t;

endpackage

`default_nettype wire

// ==== rtl/gat_bram.sv ====
`timescale 1ns/1ps
`default_nettype none

module gat_bram #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  logic [WIDTH-1:0]         wr_data,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output logic [WIDTH-1:0]         rd_data
);

  logic [WIDTH-1:0] mem [DEPTH];

  // Port A writes, port B reads with one cycle of latency
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== rtl/gat_memory_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module gat_memory_controller (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  gat_types_pkg::h_wr_t                   h_wr,
  input  gat_types_pkg::node_info_wr_t           info_wr,
  input  gat_types_pkg::wgt_wr_t                 wgt_wr,
  input  logic                                   h_data_load_done,
  input  logic                                   node_info_load_done,
  input  logic                                   wgt_load_done,
  input  logic [gat_dims_pkg::H_DATA_ADDR_W-1:0] h_addr,
  input  logic [gat_dims_pkg::NODE_ADDR_W-1:0]   info_addr,
  input  logic [gat_dims_pkg::WEIGHT_ADDR_W-1:0] wgt_addr,
  output gat_types_pkg::h_entry_t                h_entry,
  output gat_types_pkg::node_info_t              node_info,
  output gat_types_pkg::weight_t                 wgt_dout,
  output logic                                   all_loaded
);

  import gat_dims_pkg::*;
  import gat_types_pkg::*;

  logic h_wr_en;
  logic info_wr_en;
  logic wgt_wr_en;

  // Host strobes need both enable and write enable
  assign h_wr_en    = h_wr.ena & h_wr.wea;
  assign info_wr_en = info_wr.ena & info_wr.wea;
  assign wgt_wr_en  = wgt_wr.ena & wgt_wr.wea;

  gat_bram #(
    .WIDTH ($bits(h_entry_t)),
    .DEPTH (H_DATA_DEPTH)
  ) u_h_data_bram (
    .clk     (clk),
    .wr_en   (h_wr_en),
    .wr_addr (h_wr.addr),
    .wr_data (h_wr.din),
    .rd_addr (h_addr),
    .rd_data (h_entry)
  );

  gat_bram #(
    .WIDTH ($bits(node_info_t)),
    .DEPTH (TOTAL_NODES)
  ) u_node_info_bram (
    .clk     (clk),
    .wr_en   (info_wr_en),
    .wr_addr (info_wr.addr),
    .wr_data (info_wr.din),
    .rd_addr (info_addr),
    .rd_data (node_info)
  );

  gat_bram #(
    .WIDTH (DATA_WIDTH),
    .DEPTH (WEIGHT_DEPTH)
  ) u_wgt_bram (
    .clk     (clk),
    .wr_en   (wgt_wr_en),
    .wr_addr (wgt_wr.addr),
    .wr_data (wgt_wr.din),
    .rd_addr (wgt_addr),
    .rd_data (wgt_dout)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      all_loaded <= 1'b0;
    end else begin
      all_loaded <= h_data_load_done & node_info_load_done & wgt_load_done;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/gat_wh_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module gat_wh_engine (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   all_loaded,
  input  gat_types_pkg::h_entry_t                h_entry,
  input  gat_types_pkg::node_info_t              node_info,
  input  gat_types_pkg::weight_t                 wgt_dout,
  output logic [gat_dims_pkg::H_DATA_ADDR_W-1:0] h_addr,
  output logic [gat_dims_pkg::NODE_ADDR_W-1:0]   info_addr,
  output logic [gat_dims_pkg::WEIGHT_ADDR_W-1:0] wgt_addr,
  output gat_types_pkg::attn_vec_t               attn,
  output logic                                   run_start,
  output logic                                   wh_valid,
  output gat_types_pkg::wh_item_t                wh_item,
  output logic                                   run_done
);

  import gat_dims_pkg::*;
  import gat_types_pkg::*;

  engine_state_t            state;
  logic [COEF_CNT_W-1:0]    coef_cnt;
  logic [MAC_CNT_W-1:0]     mac_cnt;
  logic [ROW_LEN_WIDTH-1:0] ent_cnt;
  logic [ROW_LEN_WIDTH-1:0] row_len_q;
  logic                     first_q;
  logic                     info_wait;
  logic [NODE_ADDR_W-1:0]   node;
  logic [H_DATA_ADDR_W-1:0] h_ptr;
  wh_vec_t                  acc;
  logic [COEF_CNT_W-1:0]    coef_idx;
  logic [WGT_COL_WIDTH-1:0] acc_idx;
  logic                     last_entry;
  logic                     last_node;

  // Read data lags its address by one cycle
  assign coef_idx   = coef_cnt - 1'b1;
  assign acc_idx    = WGT_COL_WIDTH'(mac_cnt - 1'b1);
  assign last_entry = (ent_cnt + 1'b1) == row_len_q;
  assign last_node  = node == NODE_ADDR_W'(TOTAL_NODES - 1);

  assign h_addr    = h_ptr;
  assign info_addr = node;
  assign run_start = (state == LOAD_COEF) && (coef_cnt == '0);
  assign wh_valid  = state == EMIT;
  assign run_done  = state == DONE;
  assign wh_item   = '{wh: acc, node: node, first: first_q};

  // W is row-major so the entry column picks the row
  always_comb begin
    if (state == LOAD_COEF) begin
      wgt_addr = WEIGHT_ADDR_W'(A_BASE) + WEIGHT_ADDR_W'(coef_cnt);
    end else begin
      wgt_addr = WEIGHT_ADDR_W'({h_entry.col, mac_cnt[WGT_COL_WIDTH-1:0]});
    end
  end

  // ========================================
  // Sequencer
  // ========================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      coef_cnt  <= '0;
      mac_cnt   <= '0;
      ent_cnt   <= '0;
      info_wait <= 1'b0;
      node      <= '0;
      h_ptr     <= '0;
    end else if (!all_loaded) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          state     <= LOAD_COEF;
          coef_cnt  <= '0;
          mac_cnt   <= '0;
          info_wait <= 1'b0;
          node      <= '0;
          h_ptr     <= '0;
        end
        LOAD_COEF: begin
          coef_cnt <= coef_cnt + 1'b1;
          if (coef_cnt == COEF_CNT_W'(2 * NUM_FEATURE_OUT)) begin
            state <= FETCH_INFO;
          end
        end
        // Second cycle sees the node info
        FETCH_INFO: begin
          info_wait <= ~info_wait;
          if (info_wait) begin
            ent_cnt <= '0;
            state   <= (node_info.row_len == '0) ? EMIT : FETCH_ENTRY;
          end
        end
        FETCH_ENTRY: begin
          mac_cnt <= '0;
          state   <= MAC;
        end
        MAC: begin
          mac_cnt <= mac_cnt + 1'b1;
          if (mac_cnt == MAC_CNT_W'(NUM_FEATURE_OUT)) begin
            mac_cnt <= '0;
            ent_cnt <= ent_cnt + 1'b1;
            h_ptr   <= h_ptr + 1'b1;
            state   <= last_entry ? EMIT : FETCH_ENTRY;
          end
        end
        EMIT: begin
          node  <= node + 1'b1;
          state <= last_node ? DONE : FETCH_INFO;
        end
        DONE: begin
          state <= DONE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // ========================================
  // Datapath
  // ========================================
  always_ff @(posedge clk) begin
    case (state)
      IDLE: begin
        acc <= '0;
      end
      LOAD_COEF: begin
        if (coef_cnt != '0) begin
          if (coef_idx[WGT_COL_WIDTH]) begin
            attn.dst[coef_idx[WGT_COL_WIDTH-1:0]] <= wgt_dout;
          end else begin
            attn.src[coef_idx[WGT_COL_WIDTH-1:0]] <= wgt_dout;
          end
        end
      end
      FETCH_INFO: begin
        if (info_wait) begin
          row_len_q <= node_info.row_len;
          first_q   <= node_info.first;
        end
      end
      MAC: begin
        // Weight for column mac_cnt-1 arrives now
        if (mac_cnt != '0) begin
          acc[acc_idx] <= acc[acc_idx] + h_entry.value * wgt_dout;
        end
      end
      EMIT: begin
        acc <= '0;
      end
      default: begin
        acc <= acc;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/gat_attention.sv ====
`timescale 1ns/1ps
`default_nettype none

module gat_attention (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  gat_types_pkg::attn_vec_t             attn,
  input  logic                                 run_start,
  input  logic                                 wh_valid,
  input  gat_types_pkg::wh_item_t              wh_item,
  input  logic                                 run_done,
  input  logic [gat_dims_pkg::NODE_ADDR_W-1:0] score_addr,
  output logic [gat_dims_pkg::SCORE_WIDTH-1:0] score_dout,
  output logic                                 gat_ready
);

  import gat_dims_pkg::*;

  logic signed [SCORE_WIDTH-1:0] src_dot;
  logic signed [SCORE_WIDTH-1:0] dst_dot;
  logic signed [SCORE_WIDTH-1:0] src_hold;
  logic signed [SCORE_WIDTH-1:0] s1_src;
  logic signed [SCORE_WIDTH-1:0] s1_dst;
  logic [NODE_ADDR_W-1:0]        s1_node;
  logic                          s1_vld;
  logic signed [SCORE_WIDTH-1:0] sum;
  logic signed [SCORE_WIDTH-1:0] leaky;
  logic signed [SCORE_WIDTH-1:0] s2_score;
  logic [NODE_ADDR_W-1:0]        s2_node;
  logic                          s2_vld;

  // ========================================
  // Stage one
  // ========================================
  always_comb begin
    src_dot = '0;
    dst_dot = '0;
    for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
      src_dot = src_dot + attn.src[i] * wh_item.wh[i];
      dst_dot = dst_dot + attn.dst[i] * wh_item.wh[i];
    end
  end

  // ========================================
  // Stage two
  // ========================================
  // Negative sums round toward minus infinity
  assign sum   = s1_src + s1_dst;
  assign leaky = sum[SCORE_WIDTH-1] ? (sum >>> LEAKY_SHIFT) : sum;

  always_ff @(posedge clk) begin
    if (wh_valid) begin
      if (wh_item.first) begin
        src_hold <= src_dot;
      end
      // First node of a subgraph bypasses the held term
      s1_src  <= wh_item.first ? src_dot : src_hold;
      s1_dst  <= dst_dot;
      s1_node <= wh_item.node;
    end
    if (s1_vld) begin
      s2_score <= leaky;
      s2_node  <= s1_node;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_vld    <= 1'b0;
      s2_vld    <= 1'b0;
      gat_ready <= 1'b0;
    end else begin
      s1_vld <= wh_valid;
      s2_vld <= s1_vld;
      // Ready once the last write has left the pipeline
      if (run_start) begin
        gat_ready <= 1'b0;
      end else if (run_done && !s1_vld && !s2_vld) begin
        gat_ready <= 1'b1;
      end
    end
  end

  gat_bram #(
    .WIDTH (SCORE_WIDTH),
    .DEPTH (TOTAL_NODES)
  ) u_score_bram (
    .clk     (clk),
    .wr_en   (s2_vld),
    .wr_addr (s2_node),
    .wr_data (s2_score),
    .rd_addr (score_addr),
    .rd_data (score_dout)
  );

endmodule

`default_nettype wire

// ==== rtl/gat_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gat_top (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  gat_types_pkg::h_wr_t                 h_wr,
  input  gat_types_pkg::node_info_wr_t         info_wr,
  input  gat_types_pkg::wgt_wr_t               wgt_wr,
  input  logic                                 h_data_load_done,
  input  logic                                 node_info_load_done,
  input  logic                                 wgt_load_done,
  input  logic [gat_dims_pkg::NODE_ADDR_W-1:0] score_addr,
  output logic [gat_dims_pkg::SCORE_WIDTH-1:0] score_dout,
  output logic                                 gat_ready
);

  import gat_dims_pkg::*;
  import gat_types_pkg::*;

  // Memory read side
  logic [H_DATA_ADDR_W-1:0] h_addr;
  logic [NODE_ADDR_W-1:0]   info_addr;
  logic [WEIGHT_ADDR_W-1:0] wgt_addr;
  h_entry_t                 h_entry;
  node_info_t               node_info;
  weight_t                  wgt_dout;
  logic                     all_loaded;

  // Engine to attention
  attn_vec_t                attn;
  logic                     run_start;
  logic                     wh_valid;
  wh_item_t                 wh_item;
  logic                     run_done;

  gat_memory_controller u_memory_controller (
    .clk                 (clk),
    .arst_n              (arst_n),
    .h_wr                (h_wr),
    .info_wr             (info_wr),
    .wgt_wr              (wgt_wr),
    .h_data_load_done    (h_data_load_done),
    .node_info_load_done (node_info_load_done),
    .wgt_load_done       (wgt_load_done),
    .h_addr              (h_addr),
    .info_addr           (info_addr),
    .wgt_addr            (wgt_addr),
    .h_entry             (h_entry),
    .node_info           (node_info),
    .wgt_dout            (wgt_dout),
    .all_loaded          (all_loaded)
  );

  gat_wh_engine u_wh_engine (
    .clk        (clk),
    .arst_n     (arst_n),
    .all_loaded (all_loaded),
    .h_entry    (h_entry),
    .node_info  (node_info),
    .wgt_dout   (wgt_dout),
    .h_addr     (h_addr),
    .info_addr  (info_addr),
    .wgt_addr   (wgt_addr),
    .attn       (attn),
    .run_start  (run_start),
    .wh_valid   (wh_valid),
    .wh_item    (wh_item),
    .run_done   (run_done)
  );

  gat_attention u_attention (
    .clk        (clk),
    .arst_n     (arst_n),
    .attn       (attn),
    .run_start  (run_start),
    .wh_valid   (wh_valid),
    .wh_item    (wh_item),
    .run_done   (run_done),
    .score_addr (score_addr),
    .score_dout (score_dout),
    .gat_ready  (gat_ready)
  );

endmodule

`default_nettype wire

// ==== verification/gat_tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module gat_tb_clock #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release just after an edge so no flop sees it at the edge itself
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verification/gat_tb_tasks.svh ====
`ifndef GAT_TB_TASKS_SVH
`define GAT_TB_TASKS_SVH
`default_nettype none

// ========================================
// Stimulus helpers
// ========================================
// Galois LFSR stepped once for each bit taken
function automatic int lfsr_bits(input int n);
  int r;
  r = 0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
    r = (r << 1) | int'(lfsr_state[0]);
  end
  return r;
endfunction

function automatic int random_signed();
  return lfsr_bits(DATA_WIDTH) - (1 << (DATA_WIDTH - 1));
endfunction

// Drive and sample one ns after the rising edge
task automatic next_cycle();
  @(posedge clk);
  #1;
endtask

task automatic check(input string name, input logic signed [31:0] expected,
                     input logic signed [31:0] actual);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("[ERROR] %0t %s expected %0d got %0d", $time, name, expected, actual);
  end
endtask

task automatic start_test();
  test_errors_start = error_count;
endtask

task automatic finish_test(input string name);
  test_count++;
  if (error_count == test_errors_start) begin
    $display("%-22s passed", name);
  end else begin
    $display("%-22s failed with %0d errors", name, error_count - test_errors_start);
  end
endtask

// ========================================
// Reference model
// ========================================
task automatic clear_model();
  for (int i = 0; i < H_DATA_DEPTH; i++) begin
    ref_val[i] = 0;
    ref_col[i] = 0;
  end
  for (int n = 0; n < TOTAL_NODES; n++) begin
    ref_row_len[n] = 0;
    ref_size[n]    = 0;
    ref_first[n]   = 1'b0;
  end
  for (int i = 0; i < WEIGHT_DEPTH; i++) begin
    ref_wgt[i] = 0;
  end
endtask

// Sparse H times W, then e = a_src.Wh_first + a_dst.Wh_j
task automatic compute_expected();
  int ptr;
  int wh [NUM_FEATURE_OUT];
  int src_term;
  int dst_term;
  int held;
  int sum;
  int div;
  ptr  = 0;
  held = 0;
  div  = 1 << LEAKY_SHIFT;
  for (int n = 0; n < TOTAL_NODES; n++) begin
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      wh[k] = 0;
    end
    for (int e = 0; e < ref_row_len[n]; e++) begin
      for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
        wh[k] += ref_val[ptr] * ref_wgt[ref_col[ptr] * NUM_FEATURE_OUT + k];
      end
      ptr++;
    end
    src_term = 0;
    dst_term = 0;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      src_term += ref_wgt[A_BASE + k] * wh[k];
      dst_term += ref_wgt[A_BASE + NUM_FEATURE_OUT + k] * wh[k];
    end
    if (ref_first[n]) begin
      held = src_term;
    end
    sum = held + dst_term;
    // Floor of the division for negative sums
    exp_score[n] = (sum < 0) ? -((-sum + div - 1) / div) : sum;
  end
endtask

// ========================================
// Host side
// ========================================
task automatic load_memories();
  for (int i = 0; i < H_DATA_DEPTH; i++) begin
    h_wr.ena       = 1'b1;
    h_wr.wea       = 1'b1;
    h_wr.addr      = H_DATA_ADDR_W'(i);
    h_wr.din.value = DATA_WIDTH'(ref_val[i]);
    h_wr.din.col   = COL_IDX_WIDTH'(ref_col[i]);
    next_cycle();
  end
  h_wr = '0;
  for (int n = 0; n < TOTAL_NODES; n++) begin
    info_wr.ena           = 1'b1;
    info_wr.wea           = 1'b1;
    info_wr.addr          = NODE_ADDR_W'(n);
    info_wr.din.row_len   = ROW_LEN_WIDTH'(ref_row_len[n]);
    info_wr.din.num_nodes = NUM_NODE_WIDTH'(ref_size[n]);
    info_wr.din.first     = ref_first[n];
    next_cycle();
  end
  info_wr = '0;
  for (int i = 0; i < WEIGHT_DEPTH; i++) begin
    wgt_wr.ena  = 1'b1;
    wgt_wr.wea  = 1'b1;
    wgt_wr.addr = WEIGHT_ADDR_W'(i);
    wgt_wr.din  = DATA_WIDTH'(ref_wgt[i]);
    next_cycle();
  end
  wgt_wr = '0;
endtask

task automatic set_load_done(input logic level);
  h_data_load_done    = level;
  node_info_load_done = level;
  wgt_load_done       = level;
endtask

// Reload, restart, wait for gat_ready and read back every score
task automatic run_layer(input string name);
  int cycles;
  set_load_done(1'b0);
  next_cycle();
  next_cycle();
  load_memories();
  compute_expected();
  set_load_done(1'b1);
  cycles = 0;
  while (gat_ready !== 1'b0 && cycles < 16) begin
    next_cycle();
    cycles++;
  end
  if (gat_ready !== 1'b0) begin
    error_count++;
    $display("%s: gat_ready did not fall after the restart", name);
  end
  cycles = 0;
  while (gat_ready !== 1'b1 && cycles < RUN_CYCLES) begin
    next_cycle();
    cycles++;
  end
  if (gat_ready !== 1'b1) begin
    error_count++;
    $display("%s: gat_ready never rose, the run did not finish", name);
  end else begin
    for (int n = 0; n < TOTAL_NODES; n++) begin
      score_addr = NODE_ADDR_W'(n);
      next_cycle();
      check($sformatf("score_dout[%0d]", n), exp_score[n], score_dout);
    end
  end
endtask

`default_nettype wire
`endif

// ==== verification/gat_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gat_tb;

  import gat_dims_pkg::*;
  import gat_types_pkg::*;

  localparam int CLK_PERIOD_NS = 4;
  localparam int NUM_TESTS     = 6;
  localparam int RUN_CYCLES    = TOTAL_NODES * (H_DATA_DEPTH + 4) * NUM_FEATURE_OUT;
  // Loading, restart and read back
  localparam int MARGIN_CYCLES = 400;
  localparam int WATCHDOG_NS   = NUM_TESTS * (RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;

  logic                   clk;
  logic                   arst_n;
  h_wr_t                  h_wr;
  node_info_wr_t          info_wr;
  wgt_wr_t                wgt_wr;
  logic                   h_data_load_done;
  logic                   node_info_load_done;
  logic                   wgt_load_done;
  logic [NODE_ADDR_W-1:0] score_addr;
  logic [SCORE_WIDTH-1:0] score_dout;
  logic                   gat_ready;

  logic [31:0] lfsr_state;
  int          error_count;
  int          check_count;
  int          test_count;
  int          test_errors_start;

  // Reference copies of the memories
  int ref_val     [H_DATA_DEPTH];
  int ref_col     [H_DATA_DEPTH];
  int ref_row_len [TOTAL_NODES];
  int ref_size    [TOTAL_NODES];
  bit ref_first   [TOTAL_NODES];
  int ref_wgt     [WEIGHT_DEPTH];
  int exp_score   [TOTAL_NODES];

  gat_tb_clock #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (2)
  ) u_clock (
    .clk    (clk),
    .arst_n (arst_n)
  );

  gat_top dut0 (
    .clk                 (clk),
    .arst_n              (arst_n),
    .h_wr                (h_wr),
    .info_wr             (info_wr),
    .wgt_wr              (wgt_wr),
    .h_data_load_done    (h_data_load_done),
    .node_info_load_done (node_info_load_done),
    .wgt_load_done       (wgt_load_done),
    .score_addr          (score_addr),
    .score_dout          (score_dout),
    .gat_ready           (gat_ready)
  );

  // ========================================
  // Data sets
  // ========================================
  // Small W with W[r][k] = r + k + 1
  task automatic fill_ramp_weights(input int a_src, input int a_dst);
    for (int r = 0; r < NUM_FEATURE_IN; r++) begin
      for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
        ref_wgt[r * NUM_FEATURE_OUT + k] = r + k + 1;
      end
    end
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      ref_wgt[A_BASE + k]                   = a_src + k;
      ref_wgt[A_BASE + NUM_FEATURE_OUT + k] = a_dst;
    end
  endtask

  // One entry per row, subgraphs of a fixed size
  task automatic fill_single_entries(input int size);
    for (int n = 0; n < TOTAL_NODES; n++) begin
      ref_first[n]   = (n % size) == 0;
      ref_size[n]    = size;
      ref_row_len[n] = 1;
      ref_val[n]     = n + 1;
      ref_col[n]     = n % NUM_FEATURE_IN;
    end
  endtask

  // Subgraphs of 1 to MAX_NODES nodes, rows of 0 to 3 entries
  task automatic fill_random(input bit empty_inner);
    int n;
    int size;
    int ptr;
    clear_model();
    for (int i = 0; i < WEIGHT_DEPTH; i++) begin
      ref_wgt[i] = random_signed();
    end
    n   = 0;
    ptr = 0;
    while (n < TOTAL_NODES) begin
      size = lfsr_bits($clog2(MAX_NODES)) + 1;
      for (int j = 0; j < size && n < TOTAL_NODES; j++) begin
        ref_first[n]   = j == 0;
        ref_size[n]    = size;
        ref_row_len[n] = (empty_inner && j != 0 && n % 2 == 1) ? 0 : lfsr_bits(2);
        for (int e = 0; e < ref_row_len[n]; e++) begin
          ref_val[ptr] = random_signed();
          ref_col[ptr] = lfsr_bits(COL_IDX_WIDTH);
          ptr++;
        end
        n++;
      end
    end
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic test_reset_idle();
    start_test();
    for (int i = 0; i < 20; i++) begin
      check("gat_ready", 1'b0, gat_ready);
      next_cycle();
    end
    finish_test("reset_idle");
  endtask

  task automatic test_single_subgraph();
    start_test();
    clear_model();
    fill_ramp_weights(1, 2);
    fill_single_entries(TOTAL_NODES);
    run_layer("single_subgraph");
    finish_test("single_subgraph");
  endtask

  task automatic test_random_subgraphs();
    start_test();
    fill_random(1'b0);
    run_layer("random_subgraphs");
    finish_test("random_subgraphs");
  endtask

  // Negative a_dst drives most sums below zero
  task automatic test_negative_scores();
    start_test();
    clear_model();
    fill_ramp_weights(2, -3);
    fill_single_entries(MAX_NODES);
    run_layer("negative_scores");
    finish_test("negative_scores");
  endtask

  task automatic test_empty_rows();
    start_test();
    fill_random(1'b1);
    run_layer("empty_rows");
    finish_test("empty_rows");
  endtask

  // gat_ready is still high from the last run
  task automatic test_reload();
    start_test();
    check("gat_ready", 1'b1, gat_ready);
    fill_random(1'b0);
    run_layer("reload");
    finish_test("reload");
  endtask

  initial begin
    lfsr_state          = 32'h7cbd;
    error_count         = 0;
    check_count         = 0;
    test_count          = 0;
    test_errors_start   = 0;
    h_wr                = '0;
    info_wr             = '0;
    wgt_wr              = '0;
    h_data_load_done    = 1'b0;
    node_info_load_done = 1'b0;
    wgt_load_done       = 1'b0;
    score_addr          = '0;
    @(posedge arst_n);
    next_cycle();
    test_reset_idle();
    test_single_subgraph();
    test_random_subgraphs();
    test_negative_scores();
    test_empty_rows();
    test_reload();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, gat_ready never rose", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

  `include "gat_tb_tasks.svh"

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verification
rtl/gat_dims_pkg.sv
rtl/gat_types_pkg.sv
rtl/gat_bram.sv
rtl/gat_memory_controller.sv
rtl/gat_wh_engine.sv
rtl/gat_attention.sv
rtl/gat_top.sv
verification/gat_tb_clock.sv
verification/gat_tb.sv

// ==== Bender.yml ====
package:
  name: gat_layer

sources:
  - rtl/gat_dims_pkg.sv
  - rtl/gat_types_pkg.sv
  - rtl/gat_bram.sv
  - rtl/gat_memory_controller.sv
  - rtl/gat_wh_engine.sv
  - rtl/gat_attention.sv
  - rtl/gat_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/gat_tb_clock.sv
      - verification/gat_tb.sv
